//--- verilog/rvfi_check_pkg.sv
// ##########################################################
// widths, opcodes, decode and result types of the checker
// ##########################################################

package rvfi_check_pkg;

	localparam int xlen_w     = 32;
	localparam int reg_addr_w = 5;
	localparam int num_regs   = 32;
	localparam int chk_w      = 7;
	// byte address of the register block
	localparam int apb_addr_w = 8;

	// rv32i major opcodes that the checker knows
	typedef enum logic [6:0] {
		op_lui    = 7'b01_101_11,
		op_auipc  = 7'b00_101_11,
		op_jal    = 7'b11_011_11,
		op_jalr   = 7'b11_001_11,
		op_branch = 7'b11_000_11,
		op_load   = 7'b00_000_11,
		op_store  = 7'b01_000_11,
		op_alu    = 7'b01_100_11,
		op_alu_imm = 7'b00_100_11,
		op_system = 7'b11_100_11
	} opcode_e;

	typedef enum logic [3:0] {
		class_lui,
		class_auipc,
		class_jal,
		class_jalr,
		class_branch,
		class_load,
		class_store,
		class_alu,
		class_alu_imm,
		class_csr,
		class_illegal
	} insn_class_e;

	typedef struct packed {
		insn_class_e             insn_class;
		logic                    rs1_used;
		logic                    rs2_used;
		logic                    rd_used;
		logic [xlen_w-1:0]       imm;
		logic [reg_addr_w-1:0]   rs1_field;
		logic [reg_addr_w-1:0]   rs2_field;
		logic [reg_addr_w-1:0]   rd_field;
	} decode_t;

	// bit positions in the mismatch vector
	typedef enum logic [2:0] {
		chk_pc_seq   = 3'd0,
		chk_pc_next  = 3'd1,
		chk_rs_addr  = 3'd2,
		chk_rs_data  = 3'd3,
		chk_rd_addr  = 3'd4,
		chk_mem_addr = 3'd5,
		chk_illegal  = 3'd6
	} chk_bit_e;

	typedef struct packed {
		logic              valid;
		logic [chk_w-1:0]  mismatch;
		logic [xlen_w-1:0] pc;
	} check_result_t;

	// apb word offsets
	typedef enum logic [apb_addr_w-1:0] {
		reg_ctrl    = 8'h00,
		reg_status  = 8'h04,
		reg_retired = 8'h08,
		reg_errors  = 8'h0C,
		reg_bad_pc  = 8'h10
	} reg_addr_e;

endpackage

//--- verilog/rvfi_if.sv
// ##########################################################
// one rvfi retire beat, core side to checker
// ##########################################################

`timescale 1ns/1ns

interface rvfi_if;
	import rvfi_check_pkg::*;

	logic                  valid;
	logic [xlen_w-1:0]     insn;
	logic                  trap;
	logic [xlen_w-1:0]     pc_rdata;
	logic [xlen_w-1:0]     pc_wdata;
	logic [reg_addr_w-1:0] rs1_addr;
	logic [reg_addr_w-1:0] rs2_addr;
	logic [xlen_w-1:0]     rs1_rdata;
	logic [xlen_w-1:0]     rs2_rdata;
	logic [reg_addr_w-1:0] rd_addr;
	logic [xlen_w-1:0]     rd_wdata;
	logic [xlen_w-1:0]     mem_addr;

	// no ready, a beat is taken whenever valid is high
	modport src (output valid, insn, trap, pc_rdata, pc_wdata, rs1_addr, rs2_addr,
		rs1_rdata, rs2_rdata, rd_addr, rd_wdata, mem_addr);
	modport mon (input valid, insn, trap, pc_rdata, pc_wdata, rs1_addr, rs2_addr,
		rs1_rdata, rs2_rdata, rd_addr, rd_wdata, mem_addr);

endinterface

//--- verilog/insn_decoder.sv
// ##########################################################
// rv32i decode into class, operand use and immediate
// ##########################################################

`timescale 1ns/1ns

module insn_decoder (
	input  logic [rvfi_check_pkg::xlen_w-1:0] insn,
	output rvfi_check_pkg::decode_t           dec
);
	import rvfi_check_pkg::*;

	opcode_e           opcode;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	logic [xlen_w-1:0] imm_i;
	logic [xlen_w-1:0] imm_s;
	logic [xlen_w-1:0] imm_b;
	logic [xlen_w-1:0] imm_u;
	logic [xlen_w-1:0] imm_j;
	logic              alu_ok;
	logic              alu_imm_ok;
	logic              csr_ok;

	assign opcode = opcode_e'(insn[6:0]);
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	// immediates per format, all sign extended from bit 31
	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

	// funct7 0100000 only for sub and sra
	assign alu_ok = (funct7 == 7'b0000000)
		|| ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));

	// shift immediates carry funct7 in the top bits
	assign alu_imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000)
		: (funct3 == 3'b101) ? ((funct7 == 7'b0000000) || (funct7 == 7'b0100000))
		: 1'b1;

	// counter reads only, cycle time instret low and high halves
	assign csr_ok = (insn[19:15] == 5'd0) && (funct3 == 3'b010)
		&& ((insn[31:20] == 12'hC00) || (insn[31:20] == 12'hC01)
		|| (insn[31:20] == 12'hC02) || (insn[31:20] == 12'hC80)
		|| (insn[31:20] == 12'hC81) || (insn[31:20] == 12'hC82));

	always_comb begin
		dec = '0;
		dec.insn_class = class_illegal;
		dec.rs1_field = insn[19:15];
		dec.rs2_field = insn[24:20];
		dec.rd_field = insn[11:7];
		// use flags stay low for anything illegal
		case (opcode)
			op_lui: begin
				dec.insn_class = class_lui;
				dec.rd_used = 1'b1;
				dec.imm = imm_u;
			end
			op_auipc: begin
				dec.insn_class = class_auipc;
				dec.rd_used = 1'b1;
				dec.imm = imm_u;
			end
			op_jal: begin
				dec.insn_class = class_jal;
				dec.rd_used = 1'b1;
				dec.imm = imm_j;
			end
			op_jalr: begin
				if (funct3 == 3'b000) begin
					dec.insn_class = class_jalr;
					dec.rs1_used = 1'b1;
					dec.rd_used = 1'b1;
					dec.imm = imm_i;
				end
			end
			op_branch: begin
				// 010 and 011 are not branch conditions
				if ((funct3 != 3'b010) && (funct3 != 3'b011)) begin
					dec.insn_class = class_branch;
					dec.rs1_used = 1'b1;
					dec.rs2_used = 1'b1;
					dec.imm = imm_b;
				end
			end
			op_load: begin
				if ((funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111)) begin
					dec.insn_class = class_load;
					dec.rs1_used = 1'b1;
					dec.rd_used = 1'b1;
					dec.imm = imm_i;
				end
			end
			op_store: begin
				// sb sh sw
				if (funct3 <= 3'b010) begin
					dec.insn_class = class_store;
					dec.rs1_used = 1'b1;
					dec.rs2_used = 1'b1;
					dec.imm = imm_s;
				end
			end
			op_alu: begin
				if (alu_ok) begin
					dec.insn_class = class_alu;
					dec.rs1_used = 1'b1;
					dec.rs2_used = 1'b1;
					dec.rd_used = 1'b1;
				end
			end
			op_alu_imm: begin
				if (alu_imm_ok) begin
					dec.insn_class = class_alu_imm;
					dec.rs1_used = 1'b1;
					dec.rd_used = 1'b1;
					dec.imm = imm_i;
				end
			end
			op_system: begin
				if (csr_ok) begin
					dec.insn_class = class_csr;
					dec.rd_used = 1'b1;
				end
			end
			default: begin
				dec.insn_class = class_illegal;
			end
		endcase
	end

endmodule

//--- verilog/shadow_regfile.sv
// ##########################################################
// shadow register file with a known flag per register
// ##########################################################

`timescale 1ns/1ns

module shadow_regfile #(
	parameter logic [rvfi_check_pkg::xlen_w-1:0] stack_addr = 32'h0001_0000
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic [rvfi_check_pkg::reg_addr_w-1:0] rs1_addr,
	input  logic [rvfi_check_pkg::reg_addr_w-1:0] rs2_addr,
	output logic [rvfi_check_pkg::xlen_w-1:0]     rs1_data,
	output logic                                  rs1_known,
	output logic [rvfi_check_pkg::xlen_w-1:0]     rs2_data,
	output logic                                  rs2_known,
	input  logic                                  wr_en,
	input  logic [rvfi_check_pkg::reg_addr_w-1:0] wr_addr,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     wr_data
);
	import rvfi_check_pkg::*;

	logic [xlen_w-1:0]   regs [num_regs];
	logic [num_regs-1:0] known;
	logic                wr_live;

	// x0 is hardwired, never written
	assign wr_live = wr_en && (wr_addr != '0);

	// only x0 and the stack pointer are defined out of reset
	always_ff @(posedge clk) begin
		if (reset) begin
			known <= num_regs'(32'b101);
		end else if (wr_live) begin
			known[wr_addr] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			regs[2] <= stack_addr;
		end else if (wr_live) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// x0 reads as zero
	assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];
	assign rs1_known = known[rs1_addr];
	assign rs2_known = known[rs2_addr];

endmodule

//--- verilog/retire_checker.sv
// ##########################################################
// per beat comparison against expected pc and shadow state
// ##########################################################

`timescale 1ns/1ns

module retire_checker #(
	parameter logic [rvfi_check_pkg::xlen_w-1:0] reset_pc   = 32'h0001_0000,
	parameter logic [rvfi_check_pkg::xlen_w-1:0] stack_addr = 32'h0001_0000
) (
	input  logic                          clk,
	input  logic                          reset,
	rvfi_if.mon                           rvfi,
	output rvfi_check_pkg::check_result_t result
);
	import rvfi_check_pkg::*;

	decode_t           dec;
	logic [xlen_w-1:0] exp_pc;
	logic [xlen_w-1:0] rs1_data;
	logic [xlen_w-1:0] rs2_data;
	logic              rs1_known;
	logic              rs2_known;
	logic [xlen_w-1:0] pc_plus4;
	logic [xlen_w-1:0] pc_plus_imm;
	logic [xlen_w-1:0] rs1_plus_imm;
	logic              pc_next_bad;
	logic [chk_w-1:0]  mismatch;
	logic              result_valid;
	logic [chk_w-1:0]  result_mismatch;
	logic [xlen_w-1:0] result_pc;

	insn_decoder u_dec (
		.insn (rvfi.insn),
		.dec  (dec)
	);

	// reads by the insn fields, writes from rvfi rd
	shadow_regfile #(
		.stack_addr (stack_addr)
	) u_shadow (
		.clk       (clk),
		.reset     (reset),
		.rs1_addr  (dec.rs1_field),
		.rs2_addr  (dec.rs2_field),
		.rs1_data  (rs1_data),
		.rs1_known (rs1_known),
		.rs2_data  (rs2_data),
		.rs2_known (rs2_known),
		.wr_en     (rvfi.valid && (rvfi.rd_addr != '0)),
		.wr_addr   (rvfi.rd_addr),
		.wr_data   (rvfi.rd_wdata)
	);

	assign pc_plus4 = rvfi.pc_rdata + 32'd4;
	assign pc_plus_imm = rvfi.pc_rdata + dec.imm;
	// jalr target and load/store address share this sum
	assign rs1_plus_imm = rs1_data + dec.imm;

	// branch outcome is unknown so either successor passes
	always_comb begin
		case (dec.insn_class)
			class_jal: pc_next_bad = rvfi.pc_wdata != pc_plus_imm;
			class_jalr: pc_next_bad = rs1_known
				&& (rvfi.pc_wdata != {rs1_plus_imm[xlen_w-1:1], 1'b0});
			class_branch: pc_next_bad = (rvfi.pc_wdata != pc_plus4)
				&& (rvfi.pc_wdata != pc_plus_imm);
			default: pc_next_bad = rvfi.pc_wdata != pc_plus4;
		endcase
	end

	always_comb begin
		mismatch = '0;
		if (rvfi.valid) begin
			// a trap redirects the pc, skip both pc checks
			if (!rvfi.trap) begin
				mismatch[chk_pc_seq] = rvfi.pc_rdata != exp_pc;
				mismatch[chk_pc_next] = pc_next_bad;
			end
			mismatch[chk_rs_addr] = (dec.rs1_used && (rvfi.rs1_addr != dec.rs1_field))
				|| (dec.rs2_used && (rvfi.rs2_addr != dec.rs2_field));
			// data only compared once the address agrees
			mismatch[chk_rs_data] = (dec.rs1_used && (rvfi.rs1_addr == dec.rs1_field)
				&& rs1_known && (rvfi.rs1_rdata != rs1_data))
				|| (dec.rs2_used && (rvfi.rs2_addr == dec.rs2_field)
				&& rs2_known && (rvfi.rs2_rdata != rs2_data));
			mismatch[chk_rd_addr] = (dec.rd_used && (dec.rd_field != '0)
				&& (dec.rd_field != rvfi.rd_addr))
				|| (!dec.rd_used && (rvfi.rd_addr != '0));
			mismatch[chk_mem_addr] = ((dec.insn_class == class_load)
				|| (dec.insn_class == class_store))
				&& rs1_known && (rvfi.mem_addr != rs1_plus_imm);
			mismatch[chk_illegal] = (dec.insn_class == class_illegal) && !rvfi.trap;
		end
	end

	// expected pc follows the reported successor
	always_ff @(posedge clk) begin
		if (reset) begin
			exp_pc <= reset_pc;
			result_valid <= 1'b0;
		end else begin
			result_valid <= rvfi.valid;
			if (rvfi.valid) begin
				exp_pc <= rvfi.pc_wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		result_mismatch <= mismatch;
		result_pc <= rvfi.pc_rdata;
	end

	assign result = '{valid: result_valid, mismatch: result_mismatch, pc: result_pc};

endmodule

//--- verilog/monitor_regs.sv
// ##########################################################
// apb status block with mask, sticky bits, counters and irq
// ##########################################################

`timescale 1ns/1ns

module monitor_regs (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [rvfi_check_pkg::apb_addr_w-1:0] paddr,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     pwdata,
	output logic [rvfi_check_pkg::xlen_w-1:0]     prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	input  rvfi_check_pkg::check_result_t         result,
	output logic                                  mismatch_irq
);
	import rvfi_check_pkg::*;

	// interrupt enable position in ctrl
	localparam int irq_en_bit = 8;

	logic              wr_en;
	logic              mapped;
	logic [chk_w-1:0]  mask;
	logic              irq_en;
	logic [chk_w-1:0]  status;
	logic [chk_w-1:0]  set_bits;
	logic [chk_w-1:0]  clr_bits;
	logic [xlen_w-1:0] retired;
	logic [xlen_w-1:0] errors;
	logic [xlen_w-1:0] bad_pc;

	// access phase only, no wait states
	assign wr_en = psel && penable && pwrite;
	assign pready = 1'b1;
	assign pslverr = psel && penable && !mapped;

	assign set_bits = result.valid ? (result.mismatch & mask) : '0;
	// write one to clear
	assign clr_bits = (wr_en && (paddr == reg_status)) ? pwdata[chk_w-1:0] : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			mask <= '1;
			irq_en <= 1'b0;
		end else if (wr_en && (paddr == reg_ctrl)) begin
			mask <= pwdata[chk_w-1:0];
			irq_en <= pwdata[irq_en_bit];
		end
	end

	// a new mismatch wins over a clear in the same cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			status <= '0;
			retired <= '0;
			errors <= '0;
			bad_pc <= '0;
		end else begin
			status <= (status & ~clr_bits) | set_bits;
			if (result.valid) begin
				retired <= retired + 1'b1;
			end
			if (|set_bits) begin
				errors <= errors + 1'b1;
				bad_pc <= result.pc;
			end
		end
	end

	// read mux, unmapped offsets read zero
	always_comb begin
		prdata = '0;
		mapped = 1'b1;
		case (reg_addr_e'(paddr))
			reg_ctrl: begin
				prdata[chk_w-1:0] = mask;
				prdata[irq_en_bit] = irq_en;
			end
			reg_status: prdata[chk_w-1:0] = status;
			reg_retired: prdata = retired;
			reg_errors: prdata = errors;
			reg_bad_pc: prdata = bad_pc;
			default: mapped = 1'b0;
		endcase
	end

	assign mismatch_irq = irq_en && (|status);

endmodule

//--- verilog/rvfi_check_top.sv
// ##########################################################
// top level joining rvfi ports, checker and apb registers
// ##########################################################

`timescale 1ns/1ns

module rvfi_check_top #(
	parameter logic [rvfi_check_pkg::xlen_w-1:0] reset_pc   = 32'h0001_0000,
	parameter logic [rvfi_check_pkg::xlen_w-1:0] stack_addr = 32'h0001_0000
) (
	input  logic                                  clk,
	input  logic                                  reset,
	input  logic                                  rvfi_valid,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     rvfi_insn,
	input  logic                                  rvfi_trap,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     rvfi_pc_rdata,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     rvfi_pc_wdata,
	input  logic [rvfi_check_pkg::reg_addr_w-1:0] rvfi_rs1_addr,
	input  logic [rvfi_check_pkg::reg_addr_w-1:0] rvfi_rs2_addr,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     rvfi_rs1_rdata,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     rvfi_rs2_rdata,
	input  logic [rvfi_check_pkg::reg_addr_w-1:0] rvfi_rd_addr,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     rvfi_rd_wdata,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     rvfi_mem_addr,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [rvfi_check_pkg::apb_addr_w-1:0] paddr,
	input  logic [rvfi_check_pkg::xlen_w-1:0]     pwdata,
	output logic [rvfi_check_pkg::xlen_w-1:0]     prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	output logic                                  mismatch_irq
);
	import rvfi_check_pkg::*;

	check_result_t check_result;

	rvfi_if u_rvfi ();

	// source side of the retire beat
	assign u_rvfi.valid = rvfi_valid;
	assign u_rvfi.insn = rvfi_insn;
	assign u_rvfi.trap = rvfi_trap;
	assign u_rvfi.pc_rdata = rvfi_pc_rdata;
	assign u_rvfi.pc_wdata = rvfi_pc_wdata;
	assign u_rvfi.rs1_addr = rvfi_rs1_addr;
	assign u_rvfi.rs2_addr = rvfi_rs2_addr;
	assign u_rvfi.rs1_rdata = rvfi_rs1_rdata;
	assign u_rvfi.rs2_rdata = rvfi_rs2_rdata;
	assign u_rvfi.rd_addr = rvfi_rd_addr;
	assign u_rvfi.rd_wdata = rvfi_rd_wdata;
	assign u_rvfi.mem_addr = rvfi_mem_addr;

	retire_checker #(
		.reset_pc   (reset_pc),
		.stack_addr (stack_addr)
	) u_checker (
		.clk    (clk),
		.reset  (reset),
		.rvfi   (u_rvfi.mon),
		.result (check_result)
	);

	// results land here one cycle after the beat
	monitor_regs u_regs (
		.clk          (clk),
		.reset        (reset),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.result       (check_result),
		.mismatch_irq (mismatch_irq)
	);

endmodule

//--- sim/tb_checker.sv
// ##########################################################
// apb and irq watcher, compares against model values
// ##########################################################

`timescale 1ns/1ns

module tb_checker (
	input logic        clk,
	input logic        psel,
	input logic        penable,
	input logic [31:0] prdata,
	input logic        pready,
	input logic        pslverr,
	input logic        mismatch_irq
);

	int total_errors = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	// no wait states ever expected
	always @(negedge clk) begin
		if (psel && penable && pready !== 1'b1) begin
			$display("pready was low during an apb access phase");
			total_errors = total_errors + 1;
			test_errors = test_errors + 1;
		end
	end

	task automatic note_error();
		total_errors = total_errors + 1;
		test_errors = test_errors + 1;
	endtask

	task automatic expect_read(input string name, input logic [31:0] expected);
		if (prdata !== expected) begin
			$display("error %s expected %h actual %h", name, expected, prdata);
			note_error();
		end
		if (pslverr !== 1'b0) begin
			$display("%s read of a mapped register gave pslverr", name);
			note_error();
		end
	endtask

	task automatic expect_slverr(input string name);
		if (pslverr !== 1'b1) begin
			$display("%s read of an unmapped address gave no pslverr", name);
			note_error();
		end
	endtask

	task automatic expect_irq(input string name, input logic expected);
		if (mismatch_irq !== expected) begin
			$display("error %s expected %b actual %b", name, expected, mismatch_irq);
			note_error();
		end
	endtask

	// one line per finished test
	task automatic end_test(input string name);
		tests_run = tests_run + 1;
		if (test_errors == 0) begin
			$display("test %s passed", name);
		end else begin
			$display("test %s failed with %0d errors", name, test_errors);
			tests_failed = tests_failed + 1;
		end
		test_errors = 0;
	endtask

	task automatic summary();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors);
	endtask

endmodule

//--- sim/tb_top.sv
// ##########################################################
// testbench top with clock, reset, retire stream, model and apb driver
// ##########################################################

`timescale 1ns/1ns

module tb_top;
	import rvfi_check_pkg::*;

	localparam logic [31:0] reset_pc   = 32'h0001_0000;
	localparam logic [31:0] stack_addr = 32'h0001_0000;
	// beats of all tests plus 50 cycles of slack per test
	localparam int total_beats = 200 + 300 + 100 + 50;
	localparam int num_tests   = 4;
	localparam int cycle_limit = total_beats + 50 * num_tests;

	logic        clk;
	logic        reset;
	logic        rvfi_valid;
	logic [31:0] rvfi_insn;
	logic        rvfi_trap;
	logic [31:0] rvfi_pc_rdata;
	logic [31:0] rvfi_pc_wdata;
	logic [4:0]  rvfi_rs1_addr;
	logic [4:0]  rvfi_rs2_addr;
	logic [31:0] rvfi_rs1_rdata;
	logic [31:0] rvfi_rs2_rdata;
	logic [4:0]  rvfi_rd_addr;
	logic [31:0] rvfi_rd_wdata;
	logic [31:0] rvfi_mem_addr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic        pslverr;
	logic        mismatch_irq;

	integer      seed;
	int          cycles;

	// model copy of the shadow file and the register block
	logic [31:0] m_regs [32];
	logic [31:0] m_known;
	logic [31:0] m_pc;
	logic [6:0]  m_mask;
	logic        m_irq_en;
	logic [6:0]  m_status;
	logic [31:0] m_errors;
	logic [31:0] m_retired;
	logic [31:0] m_bad_pc;

	// current instruction as built
	insn_class_e b_cls;
	logic [31:0] b_insn;
	logic [31:0] b_imm;
	logic        b_rs1u;
	logic        b_rs2u;
	logic        b_rdu;

	rvfi_check_top #(
		.reset_pc   (reset_pc),
		.stack_addr (stack_addr)
	) u_dut (
		.clk            (clk),
		.reset          (reset),
		.rvfi_valid     (rvfi_valid),
		.rvfi_insn      (rvfi_insn),
		.rvfi_trap      (rvfi_trap),
		.rvfi_pc_rdata  (rvfi_pc_rdata),
		.rvfi_pc_wdata  (rvfi_pc_wdata),
		.rvfi_rs1_addr  (rvfi_rs1_addr),
		.rvfi_rs2_addr  (rvfi_rs2_addr),
		.rvfi_rs1_rdata (rvfi_rs1_rdata),
		.rvfi_rs2_rdata (rvfi_rs2_rdata),
		.rvfi_rd_addr   (rvfi_rd_addr),
		.rvfi_rd_wdata  (rvfi_rd_wdata),
		.rvfi_mem_addr  (rvfi_mem_addr),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.pslverr        (pslverr),
		.mismatch_irq   (mismatch_irq)
	);

	tb_checker u_chk (
		.clk          (clk),
		.psel         (psel),
		.penable      (penable),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.mismatch_irq (mismatch_irq)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	// random encoding of one class with its imm and use flags
	task automatic build_insn();
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [2:0]  f3;
		logic [11:0] i12;
		logic [19:0] u20;
		int          pick;
		rs1 = $random(seed);
		rs2 = $random(seed);
		rd = $random(seed);
		f3 = $random(seed);
		i12 = $random(seed);
		u20 = $random(seed);
		b_rs1u = 1'b0;
		b_rs2u = 1'b0;
		b_rdu = 1'b0;
		b_imm = '0;
		pick = {$random(seed)} % 11;
		case (pick)
			0, 1: begin
				b_cls = (pick == 0) ? class_lui : class_auipc;
				b_insn = {u20, rd, (pick == 0) ? 7'b0110111 : 7'b0010111};
				b_imm = {u20, 12'b0};
				b_rdu = 1'b1;
			end
			2: begin
				// u20 holds imm[20:1]
				b_cls = class_jal;
				b_insn = {u20[19], u20[9:0], u20[10], u20[18:11], rd, 7'b1101111};
				b_imm = {{11{u20[19]}}, u20, 1'b0};
				b_rdu = 1'b1;
			end
			3: begin
				b_cls = class_jalr;
				b_insn = {i12, rs1, 3'b000, rd, 7'b1100111};
				b_imm = sext12(i12);
				b_rs1u = 1'b1;
				b_rdu = 1'b1;
			end
			4: begin
				// skip the two reserved branch conditions
				if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd2;
				b_cls = class_branch;
				b_insn = {i12[11], i12[9:4], rs2, rs1, f3, i12[3:0], i12[10], 7'b1100011};
				b_imm = {{19{i12[11]}}, i12, 1'b0};
				b_rs1u = 1'b1;
				b_rs2u = 1'b1;
			end
			5: begin
				f3 = {$random(seed)} % 5;
				if (f3 >= 3'd3) f3 = f3 + 3'd1;
				b_cls = class_load;
				b_insn = {i12, rs1, f3, rd, 7'b0000011};
				b_imm = sext12(i12);
				b_rs1u = 1'b1;
				b_rdu = 1'b1;
			end
			6: begin
				f3 = {$random(seed)} % 3;
				b_cls = class_store;
				b_insn = {i12[11:5], rs2, rs1, f3, i12[4:0], 7'b0100011};
				b_imm = sext12(i12);
				b_rs1u = 1'b1;
				b_rs2u = 1'b1;
			end
			7: begin
				b_cls = class_alu;
				i12[11:5] = (i12[0] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'b0100000 : 7'b0;
				b_insn = {i12[11:5], rs2, rs1, f3, rd, 7'b0110011};
				b_rs1u = 1'b1;
				b_rs2u = 1'b1;
				b_rdu = 1'b1;
			end
			8: begin
				// shift immediates need a clean funct7
				if (f3 == 3'd1) i12[11:5] = 7'b0;
				if (f3 == 3'd5) i12[11:5] = i12[0] ? 7'b0100000 : 7'b0;
				b_cls = class_alu_imm;
				b_insn = {i12, rs1, f3, rd, 7'b0010011};
				b_imm = sext12(i12);
				b_rs1u = 1'b1;
				b_rdu = 1'b1;
			end
			9: begin
				pick = {$random(seed)} % 6;
				i12 = (pick < 3) ? 12'hC00 + 12'(pick) : 12'hC80 + 12'(pick - 3);
				b_cls = class_csr;
				b_insn = {i12, 5'd0, 3'b010, rd, 7'b1110011};
				b_rdu = 1'b1;
			end
			default: begin
				b_cls = class_illegal;
				pick = {$random(seed)} % 5;
				case (pick)
					0: b_insn = {u20, rd, 7'b0001011};
					1: b_insn = {i12[6:0], rs2, rs1, 3'b010, rd, 7'b1100011};
					2: b_insn = {i12, rs1, 3'b111, rd, 7'b0000011};
					3: b_insn = {i12[6:0], rs2, rs1, 3'b100, rd, 7'b0100011};
					default: b_insn = {7'b0000001, rs2, rs1, f3, rd, 7'b0110011};
				endcase
			end
		endcase
	endtask

	// mismatch rules applied to the beat on the pins
	task automatic model_beat();
		logic [6:0]  bits;
		logic [6:0]  masked;
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] tgt;
		logic [4:0]  f1;
		logic [4:0]  f2;
		logic [4:0]  fd;
		f1 = b_insn[19:15];
		f2 = b_insn[24:20];
		fd = b_insn[11:7];
		s1 = m_regs[f1];
		s2 = m_regs[f2];
		tgt = s1 + b_imm;
		bits = '0;
		if (!rvfi_trap) begin
			bits[0] = rvfi_pc_rdata != m_pc;
			if (b_cls == class_jal)
				bits[1] = rvfi_pc_wdata != rvfi_pc_rdata + b_imm;
			else if (b_cls == class_jalr)
				bits[1] = m_known[f1] && (rvfi_pc_wdata != {tgt[31:1], 1'b0});
			else if (b_cls == class_branch)
				bits[1] = (rvfi_pc_wdata != rvfi_pc_rdata + 4)
					&& (rvfi_pc_wdata != rvfi_pc_rdata + b_imm);
			else
				bits[1] = rvfi_pc_wdata != rvfi_pc_rdata + 4;
		end
		bits[2] = (b_rs1u && rvfi_rs1_addr != f1) || (b_rs2u && rvfi_rs2_addr != f2);
		bits[3] = (b_rs1u && rvfi_rs1_addr == f1 && m_known[f1] && rvfi_rs1_rdata != s1)
			|| (b_rs2u && rvfi_rs2_addr == f2 && m_known[f2] && rvfi_rs2_rdata != s2);
		bits[4] = (b_rdu && fd != 0 && fd != rvfi_rd_addr) || (!b_rdu && rvfi_rd_addr != 0);
		bits[5] = (b_cls == class_load || b_cls == class_store) && m_known[f1]
			&& rvfi_mem_addr != tgt;
		bits[6] = (b_cls == class_illegal) && !rvfi_trap;
		masked = bits & m_mask;
		m_retired = m_retired + 1;
		if (|masked) begin
			m_errors = m_errors + 1;
			m_bad_pc = rvfi_pc_rdata;
		end
		m_status = m_status | masked;
		m_pc = rvfi_pc_wdata;
		if (rvfi_rd_addr != 0) begin
			m_regs[rvfi_rd_addr] = rvfi_rd_wdata;
			m_known[rvfi_rd_addr] = 1'b1;
		end
	endtask

	// mode 0 clean, 1 any field corrupted, 2 rd address only
	task automatic drive_beat(input int mode);
		logic [31:0] s1;
		logic [31:0] s2;
		logic [31:0] tgt;
		int          kind;
		build_insn();
		s1 = m_known[b_insn[19:15]] ? m_regs[b_insn[19:15]] : $random(seed);
		s2 = m_known[b_insn[24:20]] ? m_regs[b_insn[24:20]] : $random(seed);
		tgt = s1 + b_imm;
		rvfi_valid = 1'b1;
		rvfi_insn = b_insn;
		// a clean stream traps on every illegal encoding
		if (b_cls == class_illegal)
			rvfi_trap = (mode == 0) ? 1'b1 : 1'($random(seed));
		else
			rvfi_trap = ({$random(seed)} % 16 == 0);
		rvfi_pc_rdata = m_pc;
		case (b_cls)
			class_jal: rvfi_pc_wdata = m_pc + b_imm;
			class_jalr: rvfi_pc_wdata = {tgt[31:1], 1'b0};
			class_branch: rvfi_pc_wdata = ($random(seed) & 1) ? m_pc + b_imm : m_pc + 4;
			default: rvfi_pc_wdata = m_pc + 4;
		endcase
		rvfi_rs1_addr = b_insn[19:15];
		rvfi_rs2_addr = b_insn[24:20];
		rvfi_rs1_rdata = s1;
		rvfi_rs2_rdata = s2;
		rvfi_rd_addr = b_rdu ? b_insn[11:7] : 5'd0;
		rvfi_rd_wdata = $random(seed);
		rvfi_mem_addr = (b_cls == class_load || b_cls == class_store) ? tgt : 32'd0;
		if (mode != 0 && {$random(seed)} % 8 == 0) begin
			kind = (mode == 2) ? 4 : {$random(seed)} % 6;
			case (kind)
				0: rvfi_pc_rdata = rvfi_pc_rdata ^ 32'h8;
				1: rvfi_pc_wdata = rvfi_pc_wdata ^ 32'h10;
				2: rvfi_rs1_addr = rvfi_rs1_addr ^ 5'd1;
				3: rvfi_rs1_rdata = rvfi_rs1_rdata ^ 32'd1;
				4: rvfi_rd_addr = rvfi_rd_addr ^ 5'd1;
				default: rvfi_mem_addr = rvfi_mem_addr ^ 32'h4;
			endcase
		end
		model_beat();
	endtask

	// n beats back to back, then 3 idle cycles of drain
	task automatic run_beats(input int n, input int mode);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			#1;
			drive_beat(mode);
		end
		@(posedge clk);
		#1;
		rvfi_valid = 1'b0;
		repeat (3) @(posedge clk);
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
		@(posedge clk);
		#1;
		psel = 1'b1;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		if (addr == reg_ctrl) begin
			m_mask = data[6:0];
			m_irq_en = data[8];
		end else if (addr == reg_status) begin
			m_status = m_status & ~data[6:0];
		end
	endtask

	// compare lands in the middle of the access phase
	task automatic apb_read(input string name, input logic [7:0] addr,
		input logic [31:0] expected, input logic want_err);
		@(posedge clk);
		#1;
		psel = 1'b1;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#2;
		if (want_err)
			u_chk.expect_slverr(name);
		else
			u_chk.expect_read(name, expected);
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic read_all(input string name);
		apb_read({name, " ctrl"}, reg_ctrl, {23'd0, m_irq_en, 1'b0, m_mask}, 1'b0);
		apb_read({name, " status"}, reg_status, {25'd0, m_status}, 1'b0);
		apb_read({name, " errors"}, reg_errors, m_errors, 1'b0);
		apb_read({name, " retired"}, reg_retired, m_retired, 1'b0);
		apb_read({name, " bad_pc"}, reg_bad_pc, m_bad_pc, 1'b0);
	endtask

	// cycle counter guarding the whole run
	initial begin
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles = cycles + 1;
		end
		$display("timeout, run did not finish within %0d cycles", cycle_limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'hf04980a8;
		reset = 1'b1;
		rvfi_valid = 1'b0;
		rvfi_insn = '0;
		rvfi_trap = 1'b0;
		rvfi_pc_rdata = '0;
		rvfi_pc_wdata = '0;
		rvfi_rs1_addr = '0;
		rvfi_rs2_addr = '0;
		rvfi_rs1_rdata = '0;
		rvfi_rs2_rdata = '0;
		rvfi_rd_addr = '0;
		rvfi_rd_wdata = '0;
		rvfi_mem_addr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		for (int i = 0; i < 32; i++) m_regs[i] = '0;
		m_regs[2] = stack_addr;
		m_known = 32'b101;
		m_pc = reset_pc;
		m_mask = '1;
		m_irq_en = 1'b0;
		m_status = '0;
		m_errors = '0;
		m_retired = '0;
		m_bad_pc = '0;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		run_beats(200, 0);
		// a clean stream leaves every mismatch bit clear
		apb_read("pc_retire_clean status", reg_status, 32'd0, 1'b0);
		apb_read("pc_retire_clean errors", reg_errors, 32'd0, 1'b0);
		apb_read("pc_retire_clean retired", reg_retired, 32'd200, 1'b0);
		apb_read("pc_retire_clean bad_pc", reg_bad_pc, 32'd0, 1'b0);
		u_chk.end_test("pc_retire_clean");

		run_beats(300, 1);
		read_all("random_faults");
		u_chk.end_test("random_faults");

		// rd address check masked off
		apb_write(reg_status, 32'h7f);
		apb_write(reg_ctrl, 32'h6f);
		run_beats(100, 2);
		read_all("masked_rd_addr");
		apb_write(reg_status, 32'h7f);
		apb_read("masked_rd_addr status cleared", reg_status, 32'd0, 1'b0);
		u_chk.end_test("masked_rd_addr");

		apb_write(reg_ctrl, 32'h17f);
		run_beats(50, 1);
		read_all("irq_slverr");
		u_chk.expect_irq("irq_slverr irq set", m_irq_en && (|m_status));
		apb_read("irq_slverr unmapped", 8'h14, 32'd0, 1'b1);
		apb_write(reg_status, 32'h7f);
		u_chk.expect_irq("irq_slverr irq cleared", m_irq_en && (|m_status));
		u_chk.end_test("irq_slverr");

		u_chk.summary();
		if (u_chk.total_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- all.f
verilog/rvfi_check_pkg.sv
verilog/rvfi_if.sv
verilog/insn_decoder.sv
verilog/shadow_regfile.sv
verilog/retire_checker.sv
verilog/monitor_regs.sv
verilog/rvfi_check_top.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rvfi checker testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_top -f all.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
	exit 0
fi
exit 1
